/* Bender.yml */
package:
  name: exu

sources:
  # packages
  - common/alu_pkg.sv
  - common/exu_pkg.sv
  # rtl
  - verilog/operand_mux.sv
  - verilog/int_alu.sv
  - muldiv/muldiv_fsm.sv
  - muldiv/muldiv_counter.sv
  - muldiv/muldiv_datapath.sv
  - verilog/exu_top.sv
  # testbench
  - target: test
    files:
      - test/exu_tb.sv

/* common/alu_pkg.sv */
`default_nettype none

package alu_pkg;

    // datapath widths
    localparam int xlen    = 64;
    localparam int word_w  = 32;
    localparam int shamt_w = 6;

    // iterative multiply/divide
    localparam int muldiv_iters = 64;
    localparam int cnt_w        = 7;

    // fixed result encodings
    localparam logic [xlen-1:0] res_zero      = '0;
    localparam logic [xlen-1:0] res_one       = xlen'(1);
    localparam logic [xlen-1:0] div0_quotient = '1;
    localparam logic [xlen-1:0] min_signed    = {1'b1, {(xlen-1){1'b0}}};

    typedef enum logic [4:0] {
        op_add,
        op_sub,
        op_pass_a,
        op_pass_b,
        op_xor,
        op_or,
        op_and,
        op_sll,
        op_srl,
        op_sra,
        op_slt,
        op_sltu,
        op_eq,
        op_ge,
        op_geu,
        op_mul,
        op_div,
        op_divu,
        op_rem,
        op_remu
    } alu_op_t;

    // ops handled by the iterative unit
    function automatic logic is_muldiv(alu_op_t op);
        return op inside {op_mul, op_div, op_divu, op_rem, op_remu};
    endfunction

endpackage

`default_nettype wire

/* common/exu_pkg.sv */
`default_nettype none

package exu_pkg;

    import alu_pkg::*;

    typedef enum logic {
        sel_a_rs1,
        sel_a_pc
    } sel_a_t;

    typedef enum logic [1:0] {
        sel_b_rs2,
        sel_b_csr,
        sel_b_imm
    } sel_b_t;

    // one execute request, held while in_valid is high
    typedef struct packed {
        alu_op_t         op;
        sel_a_t          sel_a;
        sel_b_t          sel_b;
        logic            word;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rs1;
        logic [xlen-1:0] rs2;
        logic [xlen-1:0] csr;
        logic [xlen-1:0] imm;
    } exu_req_t;

endpackage

`default_nettype wire

/* filelist.f */
common/alu_pkg.sv
common/exu_pkg.sv
verilog/operand_mux.sv
verilog/int_alu.sv
muldiv/muldiv_fsm.sv
muldiv/muldiv_counter.sv
muldiv/muldiv_datapath.sv
verilog/exu_top.sv
test/exu_tb.sv

/* muldiv/muldiv_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module muldiv_counter import alu_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic load,
    input  logic step,
    output logic last
);

    logic [cnt_w-1:0] cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (load) begin
            cnt <= cnt_w'(muldiv_iters - 1);
        end else if (step) begin
            cnt <= cnt - 1'b1;
        end
    end

    // high during the final step only
    assign last = step & (cnt == '0);

endmodule

`default_nettype wire

/* muldiv/muldiv_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module muldiv_datapath import alu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            load,
    input  logic            step,
    input  logic            finish,
    input  alu_op_t         op,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic [xlen-1:0] result
);

    logic            is_mul;
    logic            is_signed;
    logic            neg_a;
    logic            neg_b;
    logic [xlen-1:0] mag_a;
    logic [xlen-1:0] mag_b;

    // acc holds the product or the partial remainder
    // sh holds the multiplier bits or the dividend turning into the quotient
    // mcand holds the multiplicand or the divisor
    logic [xlen-1:0] acc;
    logic [xlen-1:0] sh;
    logic [xlen-1:0] mcand;

    logic            quot_neg;
    logic            rem_neg;
    logic            div_zero;
    logic            div_ovf;

    logic [xlen:0]   rem_shift;
    logic [xlen:0]   rem_diff;
    logic [xlen-1:0] quot_fix;
    logic [xlen-1:0] rem_fix;

    assign is_mul    = (op == op_mul);
    assign is_signed = (op == op_div) || (op == op_rem);

    // low product is sign agnostic, so mul runs unsigned
    assign neg_a = is_signed & a[xlen-1];
    assign neg_b = is_signed & b[xlen-1];
    assign mag_a = neg_a ? -a : a;
    assign mag_b = neg_b ? -b : b;

    // each restoring trial shifts in the next dividend bit and tries a subtract
    assign rem_shift = {acc, sh[xlen-1]};
    assign rem_diff  = rem_shift - {1'b0, mcand};

    always_ff @(posedge clk) begin
        if (load) begin
            acc      <= '0;
            sh       <= is_mul ? mag_b : mag_a;
            mcand    <= is_mul ? mag_a : mag_b;
            quot_neg <= neg_a ^ neg_b;
            rem_neg  <= neg_a;
            div_zero <= (b == '0);
            div_ovf  <= is_signed && (a == min_signed) && (b == '1);
        end else if (step) begin
            if (is_mul) begin
                if (sh[0]) begin
                    acc <= acc + mcand;
                end
                sh    <= sh >> 1;
                mcand <= mcand << 1;
            end else if (!rem_diff[xlen]) begin
                acc <= rem_diff[xlen-1:0];
                sh  <= {sh[xlen-2:0], 1'b1};
            end else begin
                acc <= rem_shift[xlen-1:0];
                sh  <= {sh[xlen-2:0], 1'b0};
            end
        end
    end

    // sign correction of quotient and remainder
    assign quot_fix = quot_neg ? -sh : sh;
    assign rem_fix  = rem_neg ? -acc : acc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result <= res_zero;
        end else if (finish) begin
            case (op)
                op_mul: result <= acc;
                op_div, op_divu: begin
                    if (div_zero) begin
                        result <= div0_quotient;
                    end else if (div_ovf) begin
                        result <= min_signed;
                    end else begin
                        result <= quot_fix;
                    end
                end
                op_rem, op_remu: begin
                    // divide by zero leaves the dividend in acc, rem_fix restores its sign
                    if (div_ovf) begin
                        result <= res_zero;
                    end else begin
                        result <= rem_fix;
                    end
                end
                default: result <= res_zero;
            endcase
        end
    end

endmodule

`default_nettype wire

/* muldiv/muldiv_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module muldiv_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic flush,
    input  logic last,
    output logic load,
    output logic step,
    output logic finish,
    output logic busy,
    output logic done
);

    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_run,
        st_finish
    } state_t;

    state_t state;
    state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (start) begin
                    state_nxt = st_load;
                end
            end
            st_load: state_nxt = st_run;
            st_run: begin
                if (last) begin
                    state_nxt = st_finish;
                end
            end
            st_finish: state_nxt = st_idle;
            default:   state_nxt = st_idle;
        endcase
        // flush wins over everything, including a new start
        if (flush) begin
            state_nxt = st_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            done  <= 1'b0;
        end else begin
            state <= state_nxt;
            // result is ready the cycle busy drops
            done  <= (state == st_finish) & ~flush;
        end
    end

    // datapath phase strobes
    assign load   = (state == st_load);
    assign step   = (state == st_run);
    assign finish = (state == st_finish);
    assign busy   = (state != st_idle);

endmodule

`default_nettype wire

/* test/exu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_tb import alu_pkg::*, exu_pkg::*; ();

    logic            clk;
    logic            rst_n;
    logic            flush;
    logic            in_valid;
    exu_req_t        req;
    logic [xlen-1:0] res;
    logic            res_valid;
    logic            busy;

    logic [31:0]     lcg_state;
    int              fail_count;

    exu_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (in_valid),
        .req       (req),
        .res       (res),
        .res_valid (res_valid),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [63:0] next_rand();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_step();
        lo = lcg_step();
        return {hi, lo};
    endfunction

    function automatic exu_req_t random_req(input alu_op_t op, input sel_a_t sa,
                                            input sel_b_t sb, input logic word);
        exu_req_t r;
        r.op    = op;
        r.sel_a = sa;
        r.sel_b = sb;
        r.word  = word;
        r.pc    = next_rand();
        r.rs1   = next_rand();
        r.rs2   = next_rand();
        r.csr   = next_rand();
        r.imm   = next_rand();
        return r;
    endfunction

    // reference model of every operation
    function automatic logic [63:0] expected_result(input exu_req_t r);
        logic [63:0] a;
        logic [63:0] b;
        logic [5:0]  sh;
        logic [31:0] lo;
        logic [63:0] q;
        if (r.sel_a == sel_a_pc) begin
            a = r.pc;
        end else if (r.word) begin
            a = {32'd0, r.rs1[31:0]};
        end else begin
            a = r.rs1;
        end
        case (r.sel_b)
            sel_b_csr: b = r.csr;
            sel_b_imm: b = r.imm;
            default:   b = r.rs2;
        endcase
        sh = b[5:0];
        case (r.op)
            op_add:    q = a + b;
            op_sub:    q = a - b;
            op_pass_a: q = a;
            op_pass_b: q = b;
            op_xor:    q = a ^ b;
            op_or:     q = a | b;
            op_and:    q = a & b;
            op_sll:    q = a << sh;
            op_srl:    q = a >> sh;
            op_sra: begin
                // logical shift, then fill the vacated top bits with the sign
                if (r.word) begin
                    lo = a[31:0] >> sh;
                    if (a[31]) begin
                        lo = lo | ~(32'hffff_ffff >> sh);
                    end
                    q = {32'd0, lo};
                end else begin
                    q = a >> sh;
                    if (a[63]) begin
                        q = q | ~(64'hffff_ffff_ffff_ffff >> sh);
                    end
                end
            end
            op_slt:    q = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            op_sltu:   q = (a < b) ? 64'd1 : 64'd0;
            op_eq:     q = (a == b) ? 64'd1 : 64'd0;
            op_ge:     q = ($signed(a) >= $signed(b)) ? 64'd1 : 64'd0;
            op_geu:    q = (a >= b) ? 64'd1 : 64'd0;
            op_mul:    q = a * b;
            op_divu:   q = (b == 64'd0) ? 64'hffff_ffff_ffff_ffff : a / b;
            op_remu:   q = (b == 64'd0) ? a : a % b;
            op_div: begin
                if (b == 64'd0) begin
                    q = 64'hffff_ffff_ffff_ffff;
                end else if (a == min_signed && b == 64'hffff_ffff_ffff_ffff) begin
                    q = a;
                end else begin
                    q = $signed(a) / $signed(b);
                end
            end
            op_rem: begin
                if (b == 64'd0) begin
                    q = a;
                end else if (a == min_signed && b == 64'hffff_ffff_ffff_ffff) begin
                    q = 64'd0;
                end else begin
                    q = $signed(a) % $signed(b);
                end
            end
            default:   q = 64'd0;
        endcase
        return q;
    endfunction

    task automatic abort_run(input string reason);
        fail_count++;
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic wait_result(input string name, input int limit);
        int cycles;
        cycles = 0;
        while (!res_valid) begin
            if (cycles >= limit) begin
                abort_run($sformatf("timeout: no result within %0d cycles in %s", limit, name));
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    task automatic wait_busy_low(input string name, input int limit);
        int cycles;
        cycles = 0;
        while (busy) begin
            if (cycles >= limit) begin
                abort_run($sformatf("timeout: busy stayed high for %0d cycles in %s",
                                    limit, name));
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    // every test task starts and ends on a falling edge
    task automatic run_single(input string name, input exu_req_t r);
        alu_op_t op;
        string   tag;
        op  = r.op;
        tag = $sformatf("%s %s", name, op.name());
        req      = r;
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        check_value($sformatf("%s res_valid", tag), 64'd1, {63'd0, res_valid});
        check_value(tag, expected_result(r), res);
    endtask

    task automatic run_long(input string name, input exu_req_t r);
        alu_op_t op;
        string   tag;
        op  = r.op;
        tag = $sformatf("%s %s", name, op.name());
        req      = r;
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        check_value($sformatf("%s busy", tag), 64'd1, {63'd0, busy});
        wait_result(tag, 2 * muldiv_iters + 16);
        check_value($sformatf("%s busy after done", tag), 64'd0, {63'd0, busy});
        check_value(tag, expected_result(r), res);
    endtask

    task automatic reset_test();
        check_value("reset busy", 64'd0, {63'd0, busy});
        check_value("reset res_valid", 64'd0, {63'd0, res_valid});
        check_value("reset res", 64'd0, res);
    endtask

    task automatic single_op_test();
        for (int i = int'(op_add); i <= int'(op_geu); i++) begin
            for (int sa = 0; sa < 2; sa++) begin
                for (int sb = 0; sb < 3; sb++) begin
                    run_single("single", random_req(alu_op_t'(i), sel_a_t'(sa),
                                                    sel_b_t'(sb), 1'b0));
                end
            end
        end
    endtask

    task automatic word_test();
        exu_req_t    r;
        logic [63:0] amount;
        // upper half of rs1 must vanish
        for (int k = 0; k < 4; k++) begin
            r = random_req(op_pass_a, sel_a_rs1, sel_b_rs2, 1'b1);
            r.rs1[63] = 1'b1;
            run_single("word zext", r);
            r.op = op_add;
            run_single("word zext", r);
        end
        r = random_req(op_pass_a, sel_a_pc, sel_b_imm, 1'b1);
        run_single("word pc", r);
        for (int i = int'(op_sll); i <= int'(op_sra); i++) begin
            for (int w = 0; w < 2; w++) begin
                for (int k = 0; k < 4; k++) begin
                    amount = next_rand();
                    if (k == 0) begin
                        amount[5:0] = 6'd0;
                    end else if (k == 1) begin
                        amount[5:0] = 6'd63;
                    end
                    r = random_req(alu_op_t'(i), sel_a_rs1, sel_b_imm, w[0]);
                    r.imm     = amount;
                    r.rs1[31] = (k != 3);
                    run_single("shift", r);
                end
            end
        end
    endtask

    task automatic muldiv_test();
        exu_req_t r;
        for (int i = int'(op_mul); i <= int'(op_remu); i++) begin
            for (int k = 0; k < 6; k++) begin
                r = random_req(alu_op_t'(i), sel_a_rs1, sel_b_rs2, 1'b0);
                // smaller divisors give wider quotients
                if (k[0]) begin
                    r.rs2 = r.rs2 >> (20 + 6 * k);
                end
                run_long("muldiv", r);
            end
        end
    endtask

    task automatic special_case_test();
        exu_req_t r;
        for (int i = int'(op_div); i <= int'(op_remu); i++) begin
            for (int k = 0; k < 2; k++) begin
                r = random_req(alu_op_t'(i), sel_a_rs1, sel_b_rs2, 1'b0);
                r.rs1[63] = k[0];
                r.rs2     = 64'd0;
                run_long("divide by zero", r);
            end
            r = random_req(alu_op_t'(i), sel_a_rs1, sel_b_rs2, 1'b0);
            r.rs1 = min_signed;
            r.rs2 = 64'hffff_ffff_ffff_ffff;
            run_long("overflow", r);
        end
    endtask

    task automatic flush_test();
        exu_req_t r;
        r = random_req(op_div, sel_a_rs1, sel_b_rs2, 1'b0);
        req      = r;
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        check_value("flush busy", 64'd1, {63'd0, busy});
        repeat (10) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        wait_busy_low("flush", 4);
        for (int i = 0; i < 2 * muldiv_iters + 16; i++) begin
            @(negedge clk);
            check_value("flush no result", 64'd0, {63'd0, res_valid});
        end
        // flush in the issue cycle drops the new op
        req      = random_req(op_divu, sel_a_rs1, sel_b_rs2, 1'b0);
        in_valid = 1'b1;
        flush    = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        flush    = 1'b0;
        check_value("flush at issue busy", 64'd0, {63'd0, busy});
        check_value("flush at issue res_valid", 64'd0, {63'd0, res_valid});
        // same for a single-cycle op
        req      = random_req(op_add, sel_a_rs1, sel_b_rs2, 1'b0);
        in_valid = 1'b1;
        flush    = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        flush    = 1'b0;
        check_value("flush at issue alu res_valid", 64'd0, {63'd0, res_valid});
        run_single("after flush", random_req(op_add, sel_a_rs1, sel_b_rs2, 1'b0));
    endtask

    task automatic back_to_back_test();
        exu_req_t r;
        run_long("b2b", random_req(op_mul, sel_a_rs1, sel_b_rs2, 1'b0));
        run_long("b2b", random_req(op_mul, sel_a_pc, sel_b_imm, 1'b0));
        run_single("b2b", random_req(op_sub, sel_a_rs1, sel_b_csr, 1'b0));
        run_single("b2b", random_req(op_xor, sel_a_pc, sel_b_rs2, 1'b0));
        run_single("b2b", random_req(op_slt, sel_a_rs1, sel_b_imm, 1'b0));
        r = random_req(op_srl, sel_a_rs1, sel_b_rs2, 1'b1);
        run_single("b2b", r);
        // res keeps the last result after the pulse
        @(negedge clk);
        check_value("b2b hold res_valid", 64'd0, {63'd0, res_valid});
        check_value("b2b hold res", expected_result(r), res);
    endtask

    initial begin
        lcg_state  = 32'h5c04;
        fail_count = 0;
        rst_n      = 1'b0;
        flush      = 1'b0;
        in_valid   = 1'b0;
        req        = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        reset_test();
        single_op_test();
        word_test();
        muldiv_test();
        special_case_test();
        flush_test();
        back_to_back_test();
        @(negedge clk);
        if (fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/exu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_top import alu_pkg::*, exu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,
    input  logic            in_valid,
    input  exu_req_t        req,
    output logic [xlen-1:0] res,
    output logic            res_valid,
    output logic            busy
);

    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] alu_res;
    logic            alu_valid;

    logic            start;
    alu_op_t         op_q;
    logic [xlen-1:0] a_q;
    logic [xlen-1:0] b_q;
    logic            md_load;
    logic            md_step;
    logic            md_finish;
    logic            md_last;
    logic            md_done;
    logic [xlen-1:0] md_result;
    logic [xlen-1:0] res_q;

    operand_mux u_operand_mux (
        .req (req),
        .a   (a),
        .b   (b)
    );

    // flush cancels an op issued in the same cycle
    int_alu u_int_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid & ~flush),
        .op        (req.op),
        .word      (req.word),
        .a         (a),
        .b         (b),
        .res       (alu_res),
        .alu_valid (alu_valid)
    );

    assign start = in_valid & is_muldiv(req.op);

    // req may change after start, datapath loads a cycle later
    always_ff @(posedge clk) begin
        if (start) begin
            op_q <= req.op;
            a_q  <= a;
            b_q  <= b;
        end
    end

    muldiv_fsm u_muldiv_fsm (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .flush  (flush),
        .last   (md_last),
        .load   (md_load),
        .step   (md_step),
        .finish (md_finish),
        .busy   (busy),
        .done   (md_done)
    );

    muldiv_counter u_muldiv_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (md_load),
        .step  (md_step),
        .last  (md_last)
    );

    muldiv_datapath u_muldiv_datapath (
        .clk    (clk),
        .rst_n  (rst_n),
        .load   (md_load),
        .step   (md_step),
        .finish (md_finish),
        .op     (op_q),
        .a      (a_q),
        .b      (b_q),
        .result (md_result)
    );

    assign res_valid = alu_valid | md_done;

    // new result passes straight through, otherwise hold the last one
    always_comb begin
        if (alu_valid) begin
            res = alu_res;
        end else if (md_done) begin
            res = md_result;
        end else begin
            res = res_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_q <= '0;
        end else if (res_valid) begin
            res_q <= res;
        end
    end

endmodule

`default_nettype wire

/* verilog/int_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module int_alu import alu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  alu_op_t         op,
    input  logic            word,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic [xlen-1:0] res,
    output logic            alu_valid
);

    logic               fire;
    logic [shamt_w-1:0] shamt;
    logic [word_w-1:0]  sra_word;
    logic [xlen-1:0]    sra_full;
    logic [xlen-1:0]    res_d;

    // multiply/divide ops belong to the iterative unit
    assign fire  = in_valid & ~is_muldiv(op);
    assign shamt = b[shamt_w-1:0];

    assign sra_word = $signed(a[word_w-1:0]) >>> shamt;
    assign sra_full = $signed(a) >>> shamt;

    always_comb begin
        case (op)
            op_add:    res_d = a + b;
            op_sub:    res_d = a - b;
            op_pass_a: res_d = a;
            op_pass_b: res_d = b;
            op_xor:    res_d = a ^ b;
            op_or:     res_d = a | b;
            op_and:    res_d = a & b;
            op_sll:    res_d = a << shamt;
            op_srl:    res_d = a >> shamt;
            op_sra: begin
                if (word) begin
                    res_d = {{(xlen-word_w){1'b0}}, sra_word};
                end else begin
                    res_d = sra_full;
                end
            end
            // compares yield 1 or 0
            op_slt:    res_d = ($signed(a) < $signed(b)) ? res_one : res_zero;
            op_sltu:   res_d = (a < b) ? res_one : res_zero;
            op_eq:     res_d = (a == b) ? res_one : res_zero;
            op_ge:     res_d = ($signed(a) >= $signed(b)) ? res_one : res_zero;
            op_geu:    res_d = (a >= b) ? res_one : res_zero;
            default:   res_d = res_zero;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            res <= res_d;
        end
    end

endmodule

`default_nettype wire

/* verilog/operand_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_mux import alu_pkg::*, exu_pkg::*; (
    input  exu_req_t        req,
    output logic [xlen-1:0] a,
    output logic [xlen-1:0] b
);

    logic [xlen-1:0] rs1_ext;

    // word ops see only the low half of rs1
    assign rs1_ext = req.word ? {{(xlen-word_w){1'b0}}, req.rs1[word_w-1:0]} : req.rs1;

    always_comb begin
        case (req.sel_a)
            sel_a_pc: a = req.pc;
            default:  a = rs1_ext;
        endcase
    end

    always_comb begin
        case (req.sel_b)
            sel_b_csr: b = req.csr;
            sel_b_imm: b = req.imm;
            default:   b = req.rs2;
        endcase
    end

endmodule

`default_nettype wire
